//--- rtl/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // Function field of SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_SLL = 4'd5,
        ALU_LUI = 4'd6
    } alu_op_e;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        funct_e      funct;
    } r_type_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_u;

    // SLL r0, r0, 0
    localparam logic [31:0] NOP_WORD = 32'h0000_0000;

endpackage

`default_nettype wire

//--- rtl/mips_pipe_pkg.sv
`default_nettype none

package mips_pipe_pkg;

    typedef struct packed {
        mips_isa_pkg::alu_op_e alu_op;
        logic                  use_imm;
        logic                  sign_ext;
        logic [31:0]           rs_val;
        logic [31:0]           rt_val;
        logic [15:0]           imm;
        logic [4:0]            shamt;
        logic [4:0]            dest;
        logic                  mem_rd;
        logic                  mem_wr;
        logic                  reg_we;
    } id_ex_t;

    // Result is the address for loads and stores
    typedef struct packed {
        logic [31:0] result;
        logic [31:0] store_data;
        logic [4:0]  dest;
        logic        mem_rd;
        logic        mem_wr;
        logic        reg_we;
    } ex_mm_t;

    typedef struct packed {
        logic [31:0] data;
        logic [4:0]  dest;
        logic        reg_we;
    } mm_wb_t;

endpackage

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire  [4:0]           rd_addr_a_i,
    input  wire  [4:0]           rd_addr_b_i,
    output logic [31:0]          rd_data_a_o,
    output logic [31:0]          rd_data_b_o,
    input  mips_pipe_pkg::mm_wb_t wb_i
);
    logic [31:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.reg_we && wb_i.dest != 5'd0) begin
            regs[wb_i.dest] <= wb_i.data;
        end
    end

    // Write-through covers the write-back stage
    always_comb begin
        if (rd_addr_a_i == 5'd0) begin
            rd_data_a_o = '0;
        end else if (wb_i.reg_we && wb_i.dest == rd_addr_a_i) begin
            rd_data_a_o = wb_i.data;
        end else begin
            rd_data_a_o = regs[rd_addr_a_i];
        end
        if (rd_addr_b_i == 5'd0) begin
            rd_data_b_o = '0;
        end else if (wb_i.reg_we && wb_i.dest == rd_addr_b_i) begin
            rd_data_b_o = wb_i.data;
        end else begin
            rd_data_b_o = regs[rd_addr_b_i];
        end
    end

endmodule

`default_nettype wire

//--- rtl/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  mips_isa_pkg::inst_u   inst_i,
    output mips_isa_pkg::alu_op_e alu_op_o,
    output logic                  use_imm_o,
    output logic                  sign_ext_o,
    output logic [4:0]            dest_o,
    output logic                  mem_rd_o,
    output logic                  mem_wr_o,
    output logic                  reg_we_o
);
    import mips_isa_pkg::*;

    always_comb begin
        alu_op_o   = ALU_ADD;
        use_imm_o  = 1'b0;
        sign_ext_o = 1'b0;
        dest_o     = inst_i.i.rt;
        mem_rd_o   = 1'b0;
        mem_wr_o   = 1'b0;
        reg_we_o   = 1'b0;
        case (inst_i.r.opcode)
            OP_SPECIAL: begin
                dest_o   = inst_i.r.rd;
                reg_we_o = 1'b1;
                case (inst_i.r.funct)
                    FN_ADDU: alu_op_o = ALU_ADD;
                    FN_SUBU: alu_op_o = ALU_SUB;
                    FN_AND:  alu_op_o = ALU_AND;
                    FN_OR:   alu_op_o = ALU_OR;
                    FN_SLT:  alu_op_o = ALU_SLT;
                    FN_SLL:  alu_op_o = ALU_SLL;
                    default: reg_we_o = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                use_imm_o  = 1'b1;
                sign_ext_o = 1'b1;
                reg_we_o   = 1'b1;
            end
            OP_ORI: begin
                alu_op_o  = ALU_OR;
                use_imm_o = 1'b1;
                reg_we_o  = 1'b1;
            end
            OP_LUI: begin
                alu_op_o  = ALU_LUI;
                use_imm_o = 1'b1;
                reg_we_o  = 1'b1;
            end
            OP_LW: begin
                use_imm_o  = 1'b1;
                sign_ext_o = 1'b1;
                mem_rd_o   = 1'b1;
                reg_we_o   = 1'b1;
            end
            OP_SW: begin
                use_imm_o  = 1'b1;
                sign_ext_o = 1'b1;
                mem_wr_o   = 1'b1;
            end
            // Branches, jumps and unknown opcodes write nothing
            default: dest_o = 5'd0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/operand_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module operand_bypass (
    input  wire  [4:0]            reg_addr_i,
    input  wire  [31:0]           reg_data_i,
    input  mips_pipe_pkg::ex_mm_t ex_i,
    input  mips_pipe_pkg::mm_wb_t mm_i,
    output logic [31:0]           value_o
);
    always_comb begin
        if (reg_addr_i == 5'd0) begin
            value_o = '0;
        // Load data is not ready until the memory stage
        end else if (ex_i.reg_we && !ex_i.mem_rd && ex_i.dest == reg_addr_i) begin
            value_o = ex_i.result;
        end else if (mm_i.reg_we && mm_i.dest == reg_addr_i) begin
            value_o = mm_i.data;
        end else begin
            value_o = reg_data_i;
        end
    end

endmodule

`default_nettype wire

//--- rtl/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  mips_isa_pkg::inst_u inst_i,
    input  wire  [31:0]         id_pc_i,
    input  wire  [31:0]         rs_val_i,
    input  wire  [31:0]         rt_val_i,
    output logic [31:0]         pc_o
);
    import mips_isa_pkg::*;

    logic [31:0] pc_q;
    logic [31:0] pc_next;
    logic [31:0] slot_pc;
    logic [31:0] br_target;
    logic [31:0] j_target;

    // Targets are relative to the delay slot
    assign slot_pc   = id_pc_i + 32'd4;
    assign br_target = slot_pc + {{14{inst_i.i.imm[15]}}, inst_i.i.imm, 2'b00};
    assign j_target  = {slot_pc[31:28], inst_i.i.rs, inst_i.i.rt, inst_i.i.imm, 2'b00};

    always_comb begin
        pc_next = pc_q + 32'd4;
        case (inst_i.i.opcode)
            OP_BEQ: if (rs_val_i == rt_val_i) pc_next = br_target;
            OP_BNE: if (rs_val_i != rt_val_i) pc_next = br_target;
            OP_J:   pc_next = j_target;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

//--- rtl/alu_stage.sv
`timescale 1ns/1ps
`default_nettype none

module alu_stage (
    input  mips_pipe_pkg::id_ex_t id_ex_i,
    output mips_pipe_pkg::ex_mm_t ex_mm_o
);
    import mips_isa_pkg::*;

    logic [31:0] imm_ext;
    logic [31:0] op_b;
    logic [31:0] result;

    assign imm_ext = id_ex_i.sign_ext ? {{16{id_ex_i.imm[15]}}, id_ex_i.imm}
                                      : {16'h0000, id_ex_i.imm};
    assign op_b    = id_ex_i.use_imm ? imm_ext : id_ex_i.rt_val;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD: result = id_ex_i.rs_val + op_b;
            ALU_SUB: result = id_ex_i.rs_val - op_b;
            ALU_AND: result = id_ex_i.rs_val & op_b;
            ALU_OR:  result = id_ex_i.rs_val | op_b;
            ALU_SLT: result = {31'd0, $signed(id_ex_i.rs_val) < $signed(op_b)};
            // Shift source is always rt
            ALU_SLL: result = id_ex_i.rt_val << id_ex_i.shamt;
            ALU_LUI: result = {op_b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    always_comb begin
        ex_mm_o.result     = result;
        ex_mm_o.store_data = id_ex_i.rt_val;
        ex_mm_o.dest       = id_ex_i.dest;
        ex_mm_o.mem_rd     = id_ex_i.mem_rd;
        ex_mm_o.mem_wr     = id_ex_i.mem_wr;
        ex_mm_o.reg_we     = id_ex_i.reg_we;
    end

endmodule

`default_nettype wire

//--- rtl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  mips_pipe_pkg::ex_mm_t ex_mm_i,
    input  wire  [31:0]           dbus_rdata_i,
    output logic [31:0]           dbus_addr_o,
    output logic [3:0]            dbus_be_o,
    output logic                  dbus_rd_o,
    output logic                  dbus_wr_o,
    output logic [31:0]           dbus_wdata_o,
    output mips_pipe_pkg::mm_wb_t mm_wb_o
);
    // Word access only
    assign dbus_addr_o  = ex_mm_i.result;
    assign dbus_be_o    = 4'b1111;
    assign dbus_rd_o    = ex_mm_i.mem_rd;
    assign dbus_wr_o    = ex_mm_i.mem_wr;
    assign dbus_wdata_o = ex_mm_i.store_data;

    always_comb begin
        mm_wb_o.data   = ex_mm_i.mem_rd ? dbus_rdata_i : ex_mm_i.result;
        mm_wb_o.dest   = ex_mm_i.dest;
        mm_wb_o.reg_we = ex_mm_i.reg_we;
    end

endmodule

`default_nettype wire

//--- rtl/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  wire         clk,
    input  wire         rst_n,
    output logic [31:0] ibus_addr_o,
    output logic        ibus_rd_o,
    input  wire  [31:0] ibus_rdata_i,
    output logic [31:0] dbus_addr_o,
    output logic [3:0]  dbus_be_o,
    output logic        dbus_rd_o,
    output logic        dbus_wr_o,
    output logic [31:0] dbus_wdata_o,
    input  wire  [31:0] dbus_rdata_i
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic [31:0] pc;
    inst_u       if_inst_q;
    logic [31:0] if_pc_q;

    alu_op_e     dec_alu_op;
    logic        dec_use_imm;
    logic        dec_sign_ext;
    logic [4:0]  dec_dest;
    logic        dec_mem_rd;
    logic        dec_mem_wr;
    logic        dec_reg_we;

    logic [31:0] rf_rs_val;
    logic [31:0] rf_rt_val;
    logic [31:0] rs_val;
    logic [31:0] rt_val;

    id_ex_t      id_ex_d;
    id_ex_t      id_ex_q;
    ex_mm_t      ex_mm_d;
    ex_mm_t      ex_mm_q;
    mm_wb_t      mm_wb_d;
    mm_wb_t      mm_wb_q;

    assign ibus_addr_o = pc;
    assign ibus_rd_o   = 1'b1;

    branch_unit #(
        .RESET_PC(RESET_PC)
    ) u_branch (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst_i   (if_inst_q),
        .id_pc_i  (if_pc_q),
        .rs_val_i (rs_val),
        .rt_val_i (rt_val),
        .pc_o     (pc)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_inst_q <= NOP_WORD;
            if_pc_q   <= '0;
        end else begin
            if_inst_q <= ibus_rdata_i;
            if_pc_q   <= pc;
        end
    end

    inst_decode u_decode (
        .inst_i     (if_inst_q),
        .alu_op_o   (dec_alu_op),
        .use_imm_o  (dec_use_imm),
        .sign_ext_o (dec_sign_ext),
        .dest_o     (dec_dest),
        .mem_rd_o   (dec_mem_rd),
        .mem_wr_o   (dec_mem_wr),
        .reg_we_o   (dec_reg_we)
    );

    reg_file u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_addr_a_i (if_inst_q.r.rs),
        .rd_addr_b_i (if_inst_q.r.rt),
        .rd_data_a_o (rf_rs_val),
        .rd_data_b_o (rf_rt_val),
        .wb_i        (mm_wb_q)
    );

    operand_bypass bypass_s (
        .reg_addr_i (if_inst_q.r.rs),
        .reg_data_i (rf_rs_val),
        .ex_i       (ex_mm_d),
        .mm_i       (mm_wb_d),
        .value_o    (rs_val)
    );

    operand_bypass bypass_t (
        .reg_addr_i (if_inst_q.r.rt),
        .reg_data_i (rf_rt_val),
        .ex_i       (ex_mm_d),
        .mm_i       (mm_wb_d),
        .value_o    (rt_val)
    );

    always_comb begin
        id_ex_d.alu_op   = dec_alu_op;
        id_ex_d.use_imm  = dec_use_imm;
        id_ex_d.sign_ext = dec_sign_ext;
        id_ex_d.rs_val   = rs_val;
        id_ex_d.rt_val   = rt_val;
        id_ex_d.imm      = if_inst_q.i.imm;
        id_ex_d.shamt    = if_inst_q.r.shamt;
        id_ex_d.dest     = dec_dest;
        id_ex_d.mem_rd   = dec_mem_rd;
        id_ex_d.mem_wr   = dec_mem_wr;
        id_ex_d.reg_we   = dec_reg_we;
    end

    // All-zero structs are bubbles: no memory access, no register write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_q <= '0;
            ex_mm_q <= '0;
            mm_wb_q <= '0;
        end else begin
            id_ex_q <= id_ex_d;
            ex_mm_q <= ex_mm_d;
            mm_wb_q <= mm_wb_d;
        end
    end

    alu_stage u_alu (
        .id_ex_i (id_ex_q),
        .ex_mm_o (ex_mm_d)
    );

    mem_stage u_mem (
        .ex_mm_i      (ex_mm_q),
        .dbus_rdata_i (dbus_rdata_i),
        .dbus_addr_o  (dbus_addr_o),
        .dbus_be_o    (dbus_be_o),
        .dbus_rd_o    (dbus_rd_o),
        .dbus_wr_o    (dbus_wr_o),
        .dbus_wdata_o (dbus_wdata_o),
        .mm_wb_o      (mm_wb_d)
    );

endmodule

`default_nettype wire

//--- testbench/tb_mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

    localparam int PROG_LEN    = 51;
    localparam int CYCLE_LIMIT = PROG_LEN + 40;
    localparam int DRAIN       = 6;

    // Fetch address of the final self loop
    localparam logic [31:0] END_PC    = 32'h0000_00c4;
    localparam logic [31:0] LOAD_ADDR = 32'h0000_0140;

    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    logic        clk;
    logic        rst_n;
    logic [31:0] ibus_addr;
    logic        ibus_rd;
    logic [31:0] ibus_rdata;
    logic [31:0] dbus_addr;
    logic [3:0]  dbus_be;
    logic        dbus_rd;
    logic        dbus_wr;
    logic [31:0] dbus_wdata;
    logic [31:0] dbus_rdata;

    logic [31:0] rom [0:255];
    logic [31:0] ram [0:255];
    logic [31:0] prog [0:PROG_LEN-1];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    int cycle_cnt = 0;
    int store_idx = 0;
    int load_cnt  = 0;
    int error_cnt = 0;
    int flow_err  = 0;

    mips_core #(
        .RESET_PC(32'h0000_0000)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .ibus_addr_o  (ibus_addr),
        .ibus_rd_o    (ibus_rd),
        .ibus_rdata_i (ibus_rdata),
        .dbus_addr_o  (dbus_addr),
        .dbus_be_o    (dbus_be),
        .dbus_rd_o    (dbus_rd),
        .dbus_wr_o    (dbus_wr),
        .dbus_wdata_o (dbus_wdata),
        .dbus_rdata_i (dbus_rdata)
    );

    always #4 clk = ~clk;

    // Zero-wait memories
    assign ibus_rdata = rom[ibus_addr[9:2]];
    assign dbus_rdata = ram[dbus_addr[9:2]];

    always @(posedge clk) begin
        if (rst_n && dbus_wr) begin
            ram[dbus_addr[9:2]] <= dbus_wdata;
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] rd, input logic [4:0] shamt,
                                               input logic [5:0] funct);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Target is a word index
    function automatic logic [31:0] jump_word(input logic [25:0] target);
        return {OP_J, target};
    endfunction

    task automatic add_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic load_program();
        // Immediates and r0
        prog[0]  = itype_word(OP_LUI,   5'd0,  5'd1,  16'h1234);
        prog[1]  = itype_word(OP_ORI,   5'd1,  5'd1,  16'h5678);
        prog[2]  = itype_word(OP_SW,    5'd0,  5'd1,  16'h0100);
        prog[3]  = itype_word(OP_ADDIU, 5'd0,  5'd0,  16'h0055);
        prog[4]  = itype_word(OP_SW,    5'd0,  5'd0,  16'h0104);
        // Arithmetic and logic
        prog[5]  = itype_word(OP_ADDIU, 5'd0,  5'd2,  16'h0064);
        prog[6]  = itype_word(OP_ADDIU, 5'd0,  5'd3,  16'hfff9);
        prog[7]  = rtype_word(5'd2,  5'd3,  5'd4,  5'd0, FN_ADDU);
        prog[8]  = rtype_word(5'd2,  5'd3,  5'd5,  5'd0, FN_SUBU);
        prog[9]  = rtype_word(5'd2,  5'd3,  5'd6,  5'd0, FN_AND);
        prog[10] = rtype_word(5'd2,  5'd3,  5'd7,  5'd0, FN_OR);
        prog[11] = rtype_word(5'd3,  5'd2,  5'd8,  5'd0, FN_SLT);
        prog[12] = rtype_word(5'd2,  5'd3,  5'd9,  5'd0, FN_SLT);
        prog[13] = rtype_word(5'd0,  5'd2,  5'd10, 5'd4, FN_SLL);
        prog[14] = itype_word(OP_SW,    5'd0,  5'd4,  16'h0108);
        prog[15] = itype_word(OP_SW,    5'd0,  5'd5,  16'h010c);
        prog[16] = itype_word(OP_SW,    5'd0,  5'd6,  16'h0110);
        prog[17] = itype_word(OP_SW,    5'd0,  5'd7,  16'h0114);
        prog[18] = itype_word(OP_SW,    5'd0,  5'd8,  16'h0118);
        prog[19] = itype_word(OP_SW,    5'd0,  5'd9,  16'h011c);
        prog[20] = itype_word(OP_SW,    5'd0,  5'd10, 16'h0120);
        // Dependencies at distances one, two and three
        prog[21] = itype_word(OP_ADDIU, 5'd0,  5'd11, 16'h0011);
        prog[22] = rtype_word(5'd11, 5'd11, 5'd12, 5'd0, FN_ADDU);
        prog[23] = 32'h0000_0000;
        prog[24] = rtype_word(5'd11, 5'd12, 5'd13, 5'd0, FN_ADDU);
        prog[25] = rtype_word(5'd13, 5'd12, 5'd14, 5'd0, FN_ADDU);
        prog[26] = itype_word(OP_SW,    5'd0,  5'd14, 16'h0124);
        prog[27] = itype_word(OP_SW,    5'd0,  5'd13, 16'h0128);
        // Store, load, use two slots later
        prog[28] = itype_word(OP_SW,    5'd0,  5'd1,  16'h0140);
        prog[29] = itype_word(OP_LW,    5'd0,  5'd16, 16'h0140);
        prog[30] = 32'h0000_0000;
        prog[31] = rtype_word(5'd16, 5'd2,  5'd17, 5'd0, FN_ADDU);
        prog[32] = itype_word(OP_SW,    5'd0,  5'd17, 16'h012c);
        prog[33] = itype_word(OP_SW,    5'd0,  5'd16, 16'h0130);
        // BEQ taken to 40, BNE not taken, J to 47
        prog[34] = itype_word(OP_ADDIU, 5'd0,  5'd18, 16'h0005);
        prog[35] = itype_word(OP_ADDIU, 5'd0,  5'd19, 16'h0005);
        prog[36] = itype_word(OP_BEQ,   5'd18, 5'd19, 16'h0003);
        prog[37] = itype_word(OP_SW,    5'd0,  5'd18, 16'h0134);
        prog[38] = itype_word(OP_SW,    5'd0,  5'd2,  16'h01f0);
        prog[39] = itype_word(OP_SW,    5'd0,  5'd2,  16'h01f4);
        prog[40] = itype_word(OP_BNE,   5'd18, 5'd19, 16'h0004);
        prog[41] = itype_word(OP_SW,    5'd0,  5'd18, 16'h0138);
        prog[42] = itype_word(OP_ADDIU, 5'd0,  5'd20, 16'h007e);
        prog[43] = jump_word(26'd47);
        prog[44] = itype_word(OP_SW,    5'd0,  5'd20, 16'h013c);
        prog[45] = itype_word(OP_SW,    5'd0,  5'd2,  16'h01f8);
        prog[46] = itype_word(OP_SW,    5'd0,  5'd2,  16'h01fc);
        prog[47] = itype_word(OP_ORI,   5'd0,  5'd21, 16'hbeef);
        prog[48] = itype_word(OP_SW,    5'd0,  5'd21, 16'h0144);
        prog[49] = jump_word(26'd49);
        prog[50] = 32'h0000_0000;
    endtask

    task automatic fill_store_table();
        add_store(32'h0000_0100, 32'h1234_5678);
        add_store(32'h0000_0104, 32'h0000_0000);
        add_store(32'h0000_0108, 32'h0000_005d);
        add_store(32'h0000_010c, 32'h0000_006b);
        add_store(32'h0000_0110, 32'h0000_0060);
        add_store(32'h0000_0114, 32'hffff_fffd);
        add_store(32'h0000_0118, 32'h0000_0001);
        add_store(32'h0000_011c, 32'h0000_0000);
        add_store(32'h0000_0120, 32'h0000_0640);
        add_store(32'h0000_0124, 32'h0000_0055);
        add_store(32'h0000_0128, 32'h0000_0033);
        add_store(32'h0000_0140, 32'h1234_5678);
        add_store(32'h0000_012c, 32'h1234_56dc);
        add_store(32'h0000_0130, 32'h1234_5678);
        add_store(32'h0000_0134, 32'h0000_0005);
        add_store(32'h0000_0138, 32'h0000_0005);
        add_store(32'h0000_013c, 32'h0000_007e);
        add_store(32'h0000_0144, 32'h0000_beef);
    endtask

    // Bus checks mid-cycle, where outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (ibus_rd !== 1'b1) begin
                $display("Error: ibus_rd_o = %h, expected %h", ibus_rd, 1'b1);
                error_cnt++;
            end
            if (dbus_wr) begin
                if (store_idx >= exp_addr.size()) begin
                    $display("Store to address %h was not expected", dbus_addr);
                    error_cnt++;
                end else begin
                    if (dbus_addr !== exp_addr[store_idx]) begin
                        $display("Error: dbus_addr_o = %h, expected %h", dbus_addr,
                                 exp_addr[store_idx]);
                        error_cnt++;
                    end
                    if (dbus_wdata !== exp_data[store_idx]) begin
                        $display("Error: dbus_wdata_o = %h, expected %h", dbus_wdata,
                                 exp_data[store_idx]);
                        error_cnt++;
                    end
                    if (dbus_be !== 4'hf) begin
                        $display("Error: dbus_be_o = %h, expected %h", dbus_be, 4'hf);
                        error_cnt++;
                    end
                end
                store_idx++;
            end
            if (dbus_rd) begin
                load_cnt++;
                if (dbus_addr !== LOAD_ADDR) begin
                    $display("Error: dbus_addr_o = %h, expected %h", dbus_addr, LOAD_ADDR);
                    error_cnt++;
                end
            end
        end
    end

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        load_program();
        fill_store_table();
        for (int i = 0; i < 256; i++) begin
            rom[i] = 32'h0000_0000;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            rom[i] = prog[i];
        end
        for (int i = 0; i < 256; i++) begin
            ram[i] <= 32'hda7a_0000 | 32'(i << 2);
        end

        repeat (15) @(posedge clk);
        @(negedge clk);
        if (ibus_addr !== 32'h0000_0000) begin
            $display("Error: ibus_addr_o = %h, expected %h", ibus_addr, 32'h0000_0000);
            flow_err++;
        end
        if (dbus_rd !== 1'b0 || dbus_wr !== 1'b0) begin
            $display("Error: dbus_rd_o/dbus_wr_o = %h/%h, expected 0/0", dbus_rd, dbus_wr);
            flow_err++;
        end
        @(posedge clk);
        rst_n <= 1'b1;

        while (ibus_addr !== END_PC && cycle_cnt < CYCLE_LIMIT) begin
            @(negedge clk);
        end
        if (ibus_addr !== END_PC) begin
            $display("Program did not finish within %0d cycles", CYCLE_LIMIT);
            flow_err++;
        end else begin
            repeat (DRAIN) @(negedge clk);
            if (store_idx < exp_addr.size()) begin
                $display("%0d expected stores never appeared", exp_addr.size() - store_idx);
                flow_err++;
            end
            if (load_cnt != 1) begin
                $display("Expected one load cycle on the data bus but saw %0d", load_cnt);
                flow_err++;
            end
        end

        $display("Stores seen %0d of %0d, loads %0d, errors %0d", store_idx, exp_addr.size(),
                 load_cnt, error_cnt + flow_err);
        if (error_cnt + flow_err == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
rtl/mips_isa_pkg.sv
rtl/mips_pipe_pkg.sv
rtl/reg_file.sv
rtl/inst_decode.sv
rtl/operand_bypass.sv
rtl/branch_unit.sv
rtl/alu_stage.sv
rtl/mem_stage.sv
rtl/mips_core.sv
testbench/tb_mips_core.sv

//--- run_sim.sh
#!/bin/sh
# Build the MIPS pipeline testbench with Verilator, run it, and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mips_core -f sim.f -o tb_mips_core \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_mips_core > sim.log 2>&1 || { cat sim.log; echo "Simulation failed"; exit 1; }

cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0
